//--- hw/kick_cfg_pkg.sv
/* Host register map of the clock-enable block
   Write word union with mode and ratio views, host write bundle and preset ratios */
`default_nettype none

package kick_cfg_pkg;

    // One address bit selects the register
    typedef enum logic {
        ADDR_MODE  = 1'b0,  // Mode register
        ADDR_RATIO = 1'b1   // Custom ratio register
    } reg_addr_t;

    // Mode register layout
    typedef struct packed {
        logic [17:0] spare;  // Pads to the 20 bit word
        logic        custom; // Custom ratio wins over everything
        logic        sel_60; // 6 MHz pixel rate for 60 Hz
    } mode_fields_t;

    // n enables every m clk cycles
    typedef struct packed {
        logic [9:0] n;
        logic [9:0] m;
    } ratio_t;

    // Same 20 bits read by address
    typedef union packed {
        mode_fields_t mode;
        ratio_t       ratio;
    } reg_word_u;

    // Held stable by the host while req is high
    typedef struct packed {
        reg_addr_t addr;
        reg_word_u data;
    } host_wr_t;

    localparam ratio_t RATIO_STD = '{n: 10'd32, m: 10'd125}; // 6.144 MHz from 48 MHz
    localparam ratio_t RATIO_60  = '{n: 10'd1,  m: 10'd4};   // 6 MHz from 48 MHz

endpackage

`default_nettype wire

//--- hw/kick_cen_pkg.sv
/* Enable bundles of the 48 MHz and 24 MHz domains */
`default_nettype none

package kick_cen_pkg;

    // Enables living in clk
    typedef struct packed {
        logic pxl2_cen; // Base pixel rate, about 12 MHz
        logic pxl_cen;  // Half rate, about 6 MHz
        logic ti1_src;  // Quarter rate
        logic ti2_src;  // Eighth rate
    } cen48_t;

    // Enables living in clk24
    typedef struct packed {
        logic cpu_cen;  // Crossed from pxl2_cen
        logic ti1_cen;  // Crossed from ti1_src
        logic ti2_cen;  // Crossed from ti2_src
        logic snd_cen;  // Local, about 3.58 MHz
        logic psg_cen;  // Local, half of snd_cen
    } cen24_t;

endpackage

`default_nettype wire

//--- hw/kick_clk_regs.sv
/* Mode and custom ratio registers behind a four-phase req/ack write port
   Custom ratios are range checked, the active pixel ratio is chosen from the mode bits */
`timescale 1ns/10ps
`default_nettype none

module kick_clk_regs (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         req,
    input  wire kick_cfg_pkg::host_wr_t wr,
    output logic                        ack,
    output kick_cfg_pkg::ratio_t        ratio
);

    kick_cfg_pkg::mode_fields_t mode_q;   // Stored mode bits
    kick_cfg_pkg::ratio_t       custom_q; // Stored custom ratio
    kick_cfg_pkg::ratio_t       wr_ratio; // Write word seen as a ratio
    logic                       take;     // Accept edge of the handshake
    logic                       ratio_ok;

    // New request only while ack is still low
    assign take     = req && !ack;
    assign wr_ratio = wr.data.ratio;

    // n must be nonzero and at most m/4
    // Keeps pxl2 pulses two clk24 cycles apart for the crossing
    assign ratio_ok = (wr_ratio.n != 10'd0) &&
                      ({wr_ratio.n, 2'b00} <= {2'b00, wr_ratio.m});

    // Receive side of the four-phase handshake
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack <= 1'b0;
        end else if (take) begin
            ack <= 1'b1;        // Raised on the first edge with req high
        end else if (!req) begin
            ack <= 1'b0;        // Host released req
        end
    end

    // Register writes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mode_q   <= '0;
            custom_q <= kick_cfg_pkg::RATIO_STD;
        end else if (take) begin
            unique case (wr.addr)
                kick_cfg_pkg::ADDR_MODE: begin
                    mode_q <= wr.data.mode;   // Always stored
                end
                kick_cfg_pkg::ADDR_RATIO: begin
                    if (ratio_ok) begin
                        custom_q <= wr_ratio;
                    end
                    // Bad ratio is dropped, handshake still completes
                end
            endcase
        end
    end

    // Active ratio, custom first, then 60 Hz, then standard
    always_comb begin
        if (mode_q.custom) begin
            ratio = custom_q;
        end else if (mode_q.sel_60) begin
            ratio = kick_cfg_pkg::RATIO_60;
        end else begin
            ratio = kick_cfg_pkg::RATIO_STD;
        end
    end

endmodule

`default_nettype wire

//--- hw/frac_cen.sv
/* Fractional n/m clock-enable divider with power-of-two sub-rates
   Restarts from zero whenever the ratio input changes */
`timescale 1ns/10ps
`default_nettype none

module frac_cen #(
    parameter int CEN_W = 4     // Number of outputs, at least 2
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire kick_cfg_pkg::ratio_t  ratio,
    output logic [CEN_W-1:0]           cen
);

    kick_cfg_pkg::ratio_t ratio_q;      // Ratio in use
    logic [9:0]           acc;          // Phase, always below m
    logic [10:0]          sum;          // One spare bit for the carry
    logic                 hit;          // Base enable due
    logic [9:0]           acc_nxt;
    logic [CEN_W-2:0]     cnt;          // Base pulse counter
    logic [CEN_W-1:0]     sub;          // Which outputs fire on this hit
    logic                 restart;

    assign restart = ratio != ratio_q;

    assign sum     = {1'b0, acc} + {1'b0, ratio_q.n};
    assign hit     = sum >= {1'b0, ratio_q.m};
    assign acc_nxt = hit ? sum[9:0] - ratio_q.m : sum[9:0]; // True result fits below m

    // Output k fires when the low k counter bits are all zero
    always_comb begin
        sub[0] = 1'b1;
        for (int k = 1; k < CEN_W; k++) begin
            sub[k] = sub[k-1] & ~cnt[k-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ratio_q <= '0;      // First cycle after reset is a restart
            acc     <= '0;
            cnt     <= '0;
            cen     <= '0;
        end else if (restart) begin
            ratio_q <= ratio;   // Take the new ratio
            acc     <= '0;
            cnt     <= '0;
            cen     <= '0;      // Nothing from the old ratio leaks out
        end else begin
            acc <= acc_nxt;
            cen <= hit ? sub : '0;  // Registered, one cycle after the carry
            if (hit) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/cen_cross.sv
/* Single-cycle enable transfer from clk to clk24 by toggle synchronization */
`timescale 1ns/10ps
`default_nettype none

module cen_cross (
    input  wire  clk,
    input  wire  clk24,
    input  wire  rst_n,
    input  wire  cen_in,
    output logic cen_out
);

    logic       tog;        // Source side level, flips per pulse
    logic [1:0] sync;       // Two stage synchronizer
    logic       last;       // Previous synchronized level

    // Pulse to level in clk
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tog <= 1'b0;
        end else if (cen_in) begin
            tog <= ~tog;
        end
    end

    // Synchronizer and edge history in clk24
    always_ff @(posedge clk24) begin
        if (!rst_n) begin
            sync <= '0;
            last <= 1'b0;
        end else begin
            sync <= {sync[0], tog};
            last <= sync[1];
        end
    end

    // Either edge of the toggle gives one clk24 pulse
    assign cen_out = sync[1] ^ last;

endmodule

`default_nettype wire

//--- hw/snd_cen.sv
/* Fixed-ratio fractional divider in clk24 for the sound and PSG enables */
`timescale 1ns/10ps
`default_nettype none

module snd_cen #(
    parameter int SND_N = 105,  // 3.5795 MHz from 24 MHz
    parameter int SND_M = 704
) (
    input  wire  clk24,
    input  wire  rst_n,
    output logic snd,
    output logic psg
);

    localparam int AW = $clog2(SND_M);          // Phase width
    localparam logic [AW-1:0] STEP = AW'(SND_N);
    localparam logic [AW-1:0] MOD  = AW'(SND_M);

    logic [AW-1:0] acc;         // Phase, always below SND_M
    logic [AW:0]   sum;
    logic          hit;
    logic [AW-1:0] acc_nxt;
    logic          phase;       // Low on every other snd pulse

    assign sum     = {1'b0, acc} + {1'b0, STEP};
    assign hit     = sum >= {1'b0, MOD};
    assign acc_nxt = hit ? sum[AW-1:0] - MOD : sum[AW-1:0];

    always_ff @(posedge clk24) begin
        if (!rst_n) begin
            acc   <= '0;
            phase <= 1'b0;      // First snd pulse also gives psg
            snd   <= 1'b0;
            psg   <= 1'b0;
        end else begin
            acc <= acc_nxt;
            snd <= hit;
            psg <= hit && !phase;   // Half rate
            if (hit) begin
                phase <= ~phase;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/kick_clocks.sv
/* Clock-enable generator top, register block, pixel divider,
   clk to clk24 crossings and the sound divider */
`timescale 1ns/10ps
`default_nettype none

module kick_clocks #(
    parameter int CEN_W = 4,    // Pixel divider outputs
    parameter int SND_N = 105,  // Sound enable ratio
    parameter int SND_M = 704
) (
    input  wire                         clk,    // 48 MHz
    input  wire                         clk24,  // 24 MHz
    input  wire                         rst_n,
    input  wire                         req,
    input  wire kick_cfg_pkg::host_wr_t wr,
    output logic                        ack,
    output kick_cen_pkg::cen48_t        cen48,
    output kick_cen_pkg::cen24_t        cen24
);

    kick_cfg_pkg::ratio_t ratio;        // Active pixel ratio
    logic [CEN_W-1:0]     cen_base;     // Divider outputs, base rate first
    logic                 cpu_cen;
    logic                 ti1_cen;
    logic                 ti2_cen;
    logic                 snd;
    logic                 psg;

    kick_clk_regs u_regs (
        .clk    ( clk      ),
        .rst_n  ( rst_n    ),
        .req    ( req      ),
        .wr     ( wr       ),
        .ack    ( ack      ),
        .ratio  ( ratio    )
    );

    // Pixel enables, 12 MHz nominal
    frac_cen #(.CEN_W(CEN_W)) u_pxl_cen (
        .clk    ( clk      ),
        .rst_n  ( rst_n    ),
        .ratio  ( ratio    ),
        .cen    ( cen_base )
    );

    assign cen48 = '{pxl2_cen: cen_base[0], pxl_cen: cen_base[1],
                     ti1_src:  cen_base[2], ti2_src: cen_base[3]};

    // CPU enable follows the pixel clock into clk24
    cen_cross u_cpu_cen (
        .clk     ( clk         ),
        .clk24   ( clk24       ),
        .rst_n   ( rst_n       ),
        .cen_in  ( cen_base[0] ),
        .cen_out ( cpu_cen     )
    );

    cen_cross u_ti1_cen (
        .clk     ( clk         ),
        .clk24   ( clk24       ),
        .rst_n   ( rst_n       ),
        .cen_in  ( cen_base[2] ),
        .cen_out ( ti1_cen     )    // About 3 MHz
    );

    cen_cross u_ti2_cen (
        .clk     ( clk         ),
        .clk24   ( clk24       ),
        .rst_n   ( rst_n       ),
        .cen_in  ( cen_base[3] ),
        .cen_out ( ti2_cen     )    // About 1.5 MHz
    );

    // Sound enables made locally in clk24
    snd_cen #(.SND_N(SND_N), .SND_M(SND_M)) u_snd_cen (
        .clk24  ( clk24 ),
        .rst_n  ( rst_n ),
        .snd    ( snd   ),
        .psg    ( psg   )
    );

    assign cen24 = '{cpu_cen: cpu_cen, ti1_cen: ti1_cen, ti2_cen: ti2_cen,
                     snd_cen: snd,     psg_cen: psg};

endmodule

`default_nettype wire

//--- bench/kick_clocks_assertions.sv
/* Concurrent checks on the req/ack handshake and the enable pulse shapes
   bound into kick_clocks */
`timescale 1ns/10ps
`default_nettype none

module kick_clocks_assertions (
    input wire                       clk,
    input wire                       clk24,
    input wire                       rst_n,
    input wire                       req,
    input wire                       ack,
    input wire kick_cen_pkg::cen48_t cen48,
    input wire kick_cen_pkg::cen24_t cen24
);

    logic [4:0] c24;    // clk24 enables as plain bits
    assign c24 = cen24;

    // ack only answers a pending req
    ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack) |-> $past(req))
        else $error("ack rose while req was low");

    // ack holds until the host lets go
    ack_holds: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && req) |=> ack)
        else $error("ack dropped while req was still high");

    ack_reset_low: assert property (@(posedge clk)
        !rst_n |=> !ack)
        else $error("ack high after a reset cycle");

    // No clk24 enable but cpu_cen lasts two cycles
    // pxl2 runs above half the clk24 rate in the standard mode
    cen24_single: assert property (@(posedge clk24) disable iff (!rst_n)
        (c24 & $past(c24) & 5'b01111) == 5'b0)
        else $error("cen24 enable held for more than one cycle");

    // Every toggle level is still sampled at least once
    cpu_cen_pair: assert property (@(posedge clk24) disable iff (!rst_n)
        (cen24.cpu_cen && $past(cen24.cpu_cen)) |-> !$past(cen24.cpu_cen, 2))
        else $error("cpu_cen held for more than two cycles");

    // Sub-rates only fire together with the next faster rate
    pxl_in_pxl2: assert property (@(posedge clk) disable iff (!rst_n)
        cen48.pxl_cen |-> cen48.pxl2_cen)
        else $error("pxl_cen without pxl2_cen");

    ti1_in_pxl: assert property (@(posedge clk) disable iff (!rst_n)
        cen48.ti1_src |-> cen48.pxl_cen)
        else $error("ti1_src without pxl_cen");

    ti2_in_ti1: assert property (@(posedge clk) disable iff (!rst_n)
        cen48.ti2_src |-> cen48.ti1_src)
        else $error("ti2_src without ti1_src");

endmodule

bind kick_clocks kick_clocks_assertions u_assertions (
    .clk   ( clk   ),
    .clk24 ( clk24 ),
    .rst_n ( rst_n ),
    .req   ( req   ),
    .ack   ( ack   ),
    .cen48 ( cen48 ),
    .cen24 ( cen24 )
);

`default_nettype wire

//--- bench/kick_clocks_tb.sv
/* kick_clocks testbench with both clocks, LCG driven register writes over req/ack,
   reference model of the ratio selection and pulse counting in both domains */
`timescale 1ns/10ps
`default_nettype none

module kick_clocks_tb;

    localparam int CLK_PERIOD  = 20;
    localparam int SND_N       = 105;
    localparam int SND_M       = 704;
    localparam int N_TESTS     = 40;
    localparam int WIN_MAX     = 2 * 1023 + 40;     // Longest window with gap and handshake
    localparam int WATCHDOG_NS = (N_TESTS + 2) * WIN_MAX * CLK_PERIOD;
    localparam kick_cfg_pkg::ratio_t STD_RATIO = '{n: 10'd32, m: 10'd125};
    localparam kick_cfg_pkg::ratio_t R60_RATIO = '{n: 10'd1, m: 10'd4};

    logic                   clk = 1'b0;
    logic                   clk24 = 1'b0;
    logic                   rst_n;
    logic                   req;
    kick_cfg_pkg::host_wr_t wr;
    logic                   ack;
    kick_cen_pkg::cen48_t   cen48;
    kick_cen_pkg::cen24_t   cen24;

    int unsigned          rand_state = 32'd6203;
    logic                 model_sel60 = 1'b0;        // Reference register copy
    logic                 model_custom = 1'b0;
    kick_cfg_pkg::ratio_t model_cratio = STD_RATIO;
    int                   src_cnt [3] = '{0, 0, 0};  // pxl2, ti1, ti2 in clk
    int                   dst_cnt [3] = '{0, 0, 0};  // cpu, ti1, ti2 in clk24
    logic                 snd_live = 1'b0;           // Last clk24 edge was out of reset
    int                   snd_cyc = 0;
    int                   snd_cnt = 0;
    string                cross_name [3] = '{"cpu_cen", "ti1_cen", "ti2_cen"};

    kick_clocks #(.CEN_W(4), .SND_N(SND_N), .SND_M(SND_M)) u_dut (
        .clk   ( clk   ),
        .clk24 ( clk24 ),
        .rst_n ( rst_n ),
        .req   ( req   ),
        .wr    ( wr    ),
        .ack   ( ack   ),
        .cen48 ( cen48 ),
        .cen24 ( cen24 )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Half rate clock shifted 5 ns off every clk edge
    always begin
        #5  clk24 = 1'b1;
        #20 clk24 = 1'b0;
        #15;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Done: errors found");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic int unsigned lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state >> 8;     // Low bits are weak
    endfunction

    // Ratio the registers should select
    function automatic kick_cfg_pkg::ratio_t model_ratio();
        if (model_custom) begin
            return model_cratio;
        end else if (model_sel60) begin
            return R60_RATIO;
        end else begin
            return STD_RATIO;
        end
    endfunction

    task automatic check_quiet();
        assert (cen48 == '0) else fail_now($sformatf("error: cen48 0x%0h, expected 0x0", cen48));
        assert (cen24 == '0) else fail_now($sformatf("error: cen24 0x%0h, expected 0x0", cen24));
        assert (ack == 1'b0) else fail_now($sformatf("error: ack 0x%0h, expected 0x0", ack));
    endtask

    // Four-phase write that returns on the negedge after ack falls
    task automatic write_reg(input kick_cfg_pkg::host_wr_t w);
        int waited;
        @(negedge clk);
        wr = w;                     // Data first
        @(negedge clk);
        req = 1'b1;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack && waited < 8);
        assert (waited == 1) else fail_now("ack did not rise on the first edge after req");
        req = 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (ack && waited < 8);
        assert (waited == 1) else fail_now("ack did not fall on the first edge after req dropped");
    endtask

    // Pixel enables over m*j cycles
    // Sub-rates are only known right after a restart
    task automatic check_window(input kick_cfg_pkg::ratio_t r, input int j, input bit fresh);
        int len;
        int p2;
        int p1;
        int q1;
        int q2;
        len = int'(r.m) * j;
        p2 = 0;
        p1 = 0;
        q1 = 0;
        q2 = 0;
        repeat (len) begin
            @(negedge clk);
            if (cen48.pxl2_cen) p2++;
            if (cen48.pxl_cen) p1++;
            if (cen48.ti1_src) q1++;
            if (cen48.ti2_src) q2++;
        end
        assert (p2 == int'(r.n) * j)
            else fail_now($sformatf("error: pxl2_cen count 0x%0h, expected 0x%0h",
                                    p2, int'(r.n) * j));
        if (fresh) begin
            assert (p1 == (p2 + 1) / 2)
                else fail_now($sformatf("error: pxl_cen count 0x%0h, expected 0x%0h",
                                        p1, (p2 + 1) / 2));
            assert (q1 == (p2 + 3) / 4)
                else fail_now($sformatf("error: ti1_src count 0x%0h, expected 0x%0h",
                                        q1, (p2 + 3) / 4));
            assert (q2 == (p2 + 7) / 8)
                else fail_now($sformatf("error: ti2_src count 0x%0h, expected 0x%0h",
                                        q2, (p2 + 7) / 8));
        end
    endtask

    // Crossing sources in clk
    always @(negedge clk) begin
        if (cen48.pxl2_cen) src_cnt[0]++;
        if (cen48.ti1_src) src_cnt[1]++;
        if (cen48.ti2_src) src_cnt[2]++;
    end

    always @(posedge clk24) snd_live <= rst_n;

    always @(negedge clk24) begin
        if (cen24.cpu_cen) dst_cnt[0]++;
        if (cen24.ti1_cen) dst_cnt[1]++;
        if (cen24.ti2_cen) dst_cnt[2]++;
        if (snd_live) begin
            snd_cyc++;
            // psg on even numbered snd pulses
            assert (cen24.psg_cen == (cen24.snd_cen && snd_cnt % 2 == 0))
                else fail_now($sformatf("error: psg_cen 0x%0h, expected 0x%0h", cen24.psg_cen,
                                        cen24.snd_cen && snd_cnt % 2 == 0));
            if (cen24.snd_cen) snd_cnt++;
            if (snd_cyc % SND_M == 0) begin
                assert (snd_cnt == SND_N * (snd_cyc / SND_M))
                    else fail_now($sformatf("error: snd_cen count 0x%0h, expected 0x%0h", snd_cnt,
                                            SND_N * (snd_cyc / SND_M)));
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        fail_now("watchdog expired before the tests finished");
    end

    initial begin
        kick_cfg_pkg::host_wr_t w;
        kick_cfg_pkg::ratio_t   old_r;
        int                     kind;
        int                     m;
        int                     n;
        int                     src_snap [3];
        rst_n = 1'b0;
        req   = 1'b0;
        wr    = '0;
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            if (i >= 4) check_quiet();      // Both domains have seen reset
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_quiet();                      // Divider restart cycle
        check_window(STD_RATIO, 2, 1'b1);   // Default mode straight from reset
        for (int t = 0; t < N_TESTS; t++) begin
            repeat (lcg_next() % 8) @(negedge clk);
            w     = '0;
            kind  = int'(lcg_next() % 4);
            old_r = model_ratio();
            if (kind == 0) begin
                w.addr = kick_cfg_pkg::ADDR_MODE;
                w.data.mode.spare  = 18'(lcg_next());
                w.data.mode.sel_60 = (lcg_next() & 1) != 0;
                w.data.mode.custom = (lcg_next() & 1) != 0;
                model_sel60  = w.data.mode.sel_60;
                model_custom = w.data.mode.custom;
            end else begin
                m = 4 + int'(lcg_next() % 1020);
                if (kind != 3) begin
                    n = 1 + int'(lcg_next() % (m / 4));                 // Within n <= m/4
                end else if ((lcg_next() & 1) != 0) begin
                    n = 0;
                end else begin
                    n = m / 4 + 1 + int'(lcg_next() % (1023 - m / 4));  // Too fast
                end
                w.addr = kick_cfg_pkg::ADDR_RATIO;
                w.data.ratio.n = 10'(n);
                w.data.ratio.m = 10'(m);
                if (n != 0 && 4 * n <= m) begin
                    model_cratio = w.data.ratio;
                end
            end
            write_reg(w);
            check_window(model_ratio(), 1 + int'(lcg_next() % 2), model_ratio() != old_r);
        end
        // Everything sent before the snapshot has landed and nothing extra
        @(posedge clk);
        src_snap = src_cnt;
        repeat (8) @(posedge clk);
        for (int k = 0; k < 3; k++) begin
            assert (dst_cnt[k] >= src_snap[k] && dst_cnt[k] <= src_cnt[k])
                else fail_now($sformatf("error: %s count 0x%0h, expected 0x%0h to 0x%0h",
                                        cross_name[k], dst_cnt[k], src_snap[k], src_cnt[k]));
        end
        assert (snd_cyc >= SND_M) else fail_now("no full sound window was checked");
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hw/kick_cfg_pkg.sv
hw/kick_cen_pkg.sv
hw/kick_clk_regs.sv
hw/frac_cen.sv
hw/cen_cross.sv
hw/snd_cen.sv
hw/kick_clocks.sv
bench/kick_clocks_assertions.sv
bench/kick_clocks_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile the kick_clocks testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f files.f --top-module kick_clocks_tb -o kick_clocks_sim \
    && ./obj_dir/kick_clocks_sim 2>&1 | tee "$LOG"

grep -qx "Done: no errors" "$LOG" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
